//--- rtl/crc_check_config.svh
// build-time sizes shared by the frame CRC checker
// include wherever a width or the lane count is needed

`ifndef CRC_CHECK_CONFIG_SVH
`define CRC_CHECK_CONFIG_SVH

// one frame word on the input port
`define WORD_W 16

// CRC-16, x^16 + x^12 + x^5 + 1
`define CRC_W 16

// bit-serial lanes working side by side
`define NUM_LANES 4

// frame sequence number, wraps around
`define FRAME_ID_W 8

`endif

//--- rtl/crc_check_pkg.sv
// types shared by the frame CRC checker blocks
// modules pull these in with a wildcard import in their header

`include "crc_check_config.svh"

package crc_check_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`CRC_W-1:0]      crc_t;
    typedef logic [`FRAME_ID_W-1:0] frame_id_t;

    // word as seen on the input port, last marks the appended CRC
    typedef struct packed {
        word_t data;
        logic  last;
    } in_word_t;

    // one verdict per frame
    typedef struct packed {
        frame_id_t id;
        logic      ok;
        crc_t      crc;
    } frame_result_t;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        WAIT_WORD,
        DONE
    } lane_state_t;

endpackage

//--- rtl/crc_engine.sv
// CRC register that folds DATA_WIDTH bits per enabled cycle
// supports 8, 16, 32 and 64 bit polynomials, clear_i restarts from all ones

`timescale 1ns/1ns

module crc_engine #(
    parameter int DATA_WIDTH = 16,
    parameter int CRC_WIDTH  = 16,
    parameter bit LSB_FIRST  = 1'b0,
    parameter bit INVERT_OUT = 1'b0
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  clear_i,
    input  logic                  en_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic [CRC_WIDTH-1:0]  crc_o
);

    // generator polynomials without the top term
    localparam logic [63:0] POLY_ALL =
        (CRC_WIDTH == 8)  ? 64'h0000_0000_0000_0007 :
        (CRC_WIDTH == 16) ? 64'h0000_0000_0000_1021 :
        (CRC_WIDTH == 32) ? 64'h0000_0000_04C1_1DB7 :
                            64'h0000_0000_0000_001B;

    localparam logic [CRC_WIDTH-1:0] POLY     = POLY_ALL[CRC_WIDTH-1:0];
    localparam logic [CRC_WIDTH-1:0] CRC_INIT = '1;

    logic [CRC_WIDTH-1:0] crc_q;

    // one step of the serial LFSR
    function automatic logic [CRC_WIDTH-1:0] fold_bit(
        input logic [CRC_WIDTH-1:0] crc,
        input logic                 din
    );
        logic fb;
        fb = crc[CRC_WIDTH-1] ^ din;
        return (crc << 1) ^ ({CRC_WIDTH{fb}} & POLY);
    endfunction

    function automatic logic [CRC_WIDTH-1:0] fold_word(
        input logic [CRC_WIDTH-1:0]  crc,
        input logic [DATA_WIDTH-1:0] data
    );
        logic [CRC_WIDTH-1:0] acc;
        acc = crc;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (LSB_FIRST) begin
                acc = fold_bit(acc, data[i]);
            end else begin
                acc = fold_bit(acc, data[DATA_WIDTH-1-i]);
            end
        end
        return acc;
    endfunction

    // clear together with en starts a new value from the first data
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            crc_q <= CRC_INIT;
        end else if (en_i) begin
            crc_q <= fold_word(clear_i ? CRC_INIT : crc_q, data_i);
        end else if (clear_i) begin
            crc_q <= CRC_INIT;
        end
    end

    assign crc_o = INVERT_OUT ? ~crc_q : crc_q;

endmodule

//--- rtl/crc_lane.sv
// one bit-serial checking lane, takes a frame word by word from the dispatcher
// and holds a verdict in DONE until the collector takes it

`timescale 1ns/1ns
`include "crc_check_config.svh"

module crc_lane
    import crc_check_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          load_i,
    input  in_word_t      word_i,
    input  frame_id_t     id_i,
    input  logic          take_i,
    output logic          ready_o,
    output logic          done_o,
    output frame_result_t result_o
);

    localparam int CNT_W = $clog2(`WORD_W);

    lane_state_t      state_q;
    logic [CNT_W-1:0] cnt_q;
    word_t            shift_q;
    frame_id_t        id_q;
    frame_result_t    result_q;

    logic      start;
    logic      accept;
    logic      eng_en;
    logic      eng_bit;
    crc_t      eng_crc;
    crc_t      crc_now;
    frame_id_t id_now;

    assign ready_o = (state_q == IDLE) || (state_q == WAIT_WORD);
    assign done_o  = (state_q == DONE);
    assign start   = load_i && (state_q == IDLE);
    assign accept  = load_i && ready_o;

    // first bit goes straight from the input, the rest from the shift register
    assign eng_en  = (state_q == SHIFT) || (accept && !word_i.last);
    assign eng_bit = (state_q == SHIFT) ? shift_q[`WORD_W-1] : word_i.data[`WORD_W-1];

    // a CRC-only frame is checked against the initial value
    assign crc_now = (state_q == IDLE) ? '1 : eng_crc;
    assign id_now  = (state_q == IDLE) ? id_i : id_q;

    crc_engine #(
        .DATA_WIDTH(1),
        .CRC_WIDTH (`CRC_W),
        .LSB_FIRST (1'b0),
        .INVERT_OUT(1'b0)
    ) u_crc_engine (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(start),
        .en_i   (eng_en),
        .data_i (eng_bit),
        .crc_o  (eng_crc)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE, WAIT_WORD: begin
                    if (load_i && word_i.last) begin
                        state_q <= DONE;
                    end else if (load_i) begin
                        state_q <= SHIFT;
                        cnt_q   <= CNT_W'(`WORD_W - 2);
                    end
                end
                SHIFT: begin
                    if (cnt_q == '0) begin
                        state_q <= WAIT_WORD;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                DONE: begin
                    if (take_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && !word_i.last) begin
            shift_q <= {word_i.data[`WORD_W-2:0], 1'b0};
        end else if (state_q == SHIFT) begin
            shift_q <= {shift_q[`WORD_W-2:0], 1'b0};
        end
        if (start) begin
            id_q <= id_i;
        end
        if (accept && word_i.last) begin
            result_q <= '{id: id_now, ok: (word_i.data == crc_now), crc: crc_now};
        end
    end

    assign result_o = result_q;

endmodule

//--- rtl/frame_dispatch.sv
// input side of the checker, runs the four-phase port and hands words to lanes
// each frame gets a sequence number and the next lane in round-robin order

`timescale 1ns/1ns
`include "crc_check_config.svh"

module frame_dispatch
    import crc_check_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  in_req_i,
    input  in_word_t              in_word_i,
    output logic                  in_ack_o,
    input  logic [`NUM_LANES-1:0] lane_ready_i,
    output logic [`NUM_LANES-1:0] lane_load_o,
    output in_word_t              lane_word_o,
    output frame_id_t             lane_id_o
);

    localparam int LANE_W = $clog2(`NUM_LANES);

    logic [LANE_W-1:0] ptr_q;
    frame_id_t         frame_q;
    logic              ack_q;
    logic              load;

    // new request, not yet acknowledged, and the target lane can take it
    assign load = in_req_i && !ack_q && lane_ready_i[ptr_q];

    always_comb begin
        lane_load_o        = '0;
        lane_load_o[ptr_q] = load;
    end

    // word is held stable by the source while req is high
    assign lane_word_o = in_word_i;
    assign lane_id_o   = frame_q;
    assign in_ack_o    = ack_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q   <= '0;
            frame_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            if (load) begin
                ack_q <= 1'b1;
            end else if (ack_q && !in_req_i) begin
                ack_q <= 1'b0;
            end
            // frame ends, move on to the next lane
            if (load && in_word_i.last) begin
                frame_q <= frame_q + 1'b1;
                if (ptr_q == LANE_W'(`NUM_LANES - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= ptr_q + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/result_collect.sv
// output side of the checker, drains lanes in round-robin order
// so results leave over the four-phase port in frame order

`timescale 1ns/1ns
`include "crc_check_config.svh"

module result_collect
    import crc_check_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [`NUM_LANES-1:0] lane_done_i,
    input  frame_result_t         lane_result_i [`NUM_LANES],
    output logic [`NUM_LANES-1:0] lane_take_o,
    output logic                  out_req_o,
    output frame_result_t         out_result_o,
    input  logic                  out_ack_i
);

    localparam int LANE_W = $clog2(`NUM_LANES);

    logic [LANE_W-1:0] ptr_q;
    logic              req_q;
    logic              take_q;
    frame_result_t     result_q;
    logic              capture;

    // previous handshake fully closed and the pointed lane has a verdict
    assign capture = !req_q && !take_q && !out_ack_i && lane_done_i[ptr_q];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q  <= '0;
            req_q  <= 1'b0;
            take_q <= 1'b0;
        end else begin
            take_q <= req_q && out_ack_i;
            if (capture) begin
                req_q <= 1'b1;
            end else if (req_q && out_ack_i) begin
                req_q <= 1'b0;
            end
            // lane released, look at the next one
            if (take_q) begin
                ptr_q <= (ptr_q == LANE_W'(`NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            result_q <= lane_result_i[ptr_q];
        end
    end

    always_comb begin
        lane_take_o        = '0;
        lane_take_o[ptr_q] = take_q;
    end

    assign out_req_o    = req_q;
    assign out_result_o = result_q;

endmodule

//--- rtl/crc_check_top.sv
// frame CRC checker, dispatcher feeding parallel bit-serial lanes
// and a collector that returns one result per frame in arrival order

`timescale 1ns/1ns
`include "crc_check_config.svh"

module crc_check_top
    import crc_check_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          in_req_i,
    input  in_word_t      in_word_i,
    output logic          in_ack_o,
    output logic          out_req_o,
    output frame_result_t out_result_o,
    input  logic          out_ack_i
);

    logic [`NUM_LANES-1:0] lane_ready;
    logic [`NUM_LANES-1:0] lane_load;
    logic [`NUM_LANES-1:0] lane_done;
    logic [`NUM_LANES-1:0] lane_take;
    in_word_t              lane_word;
    frame_id_t             lane_id;
    frame_result_t         lane_result [`NUM_LANES];

    frame_dispatch u_frame_dispatch (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_req_i    (in_req_i),
        .in_word_i   (in_word_i),
        .in_ack_o    (in_ack_o),
        .lane_ready_i(lane_ready),
        .lane_load_o (lane_load),
        .lane_word_o (lane_word),
        .lane_id_o   (lane_id)
    );

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        crc_lane u_crc_lane (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .load_i  (lane_load[g]),
            .word_i  (lane_word),
            .id_i    (lane_id),
            .take_i  (lane_take[g]),
            .ready_o (lane_ready[g]),
            .done_o  (lane_done[g]),
            .result_o(lane_result[g])
        );
    end

    result_collect u_result_collect (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .lane_done_i  (lane_done),
        .lane_result_i(lane_result),
        .lane_take_o  (lane_take),
        .out_req_o    (out_req_o),
        .out_result_o (out_result_o),
        .out_ack_i    (out_ack_i)
    );

endmodule

//--- testbench/tb_crc_check.sv
// testbench for the frame CRC checker
// replays the frames of the vectors file and checks one result per frame, in order

`timescale 1ns/1ns

module tb_crc_check
    import crc_check_pkg::*;
();

    localparam string VEC_FILE     = "testbench/crc_check_vectors.txt";
    localparam int    RESET_CYCLES = 3;

    logic          clk;
    logic          rst;
    logic          in_req;
    in_word_t      in_word;
    logic          in_ack;
    logic          out_req;
    frame_result_t out_result;
    logic          out_ack;
    logic          go;

    // stimulus words and the expected verdicts, filled from the vectors file
    word_t         stim_data_q [$];
    logic          stim_last_q [$];
    frame_result_t exp_q [$];

    int num_frames;
    int num_words;
    int results_seen;
    int errors;
    int cycle_cnt;
    int cycle_limit;

    crc_check_top u_crc_check_top (
        .clk_i       (clk),
        .rst_i       (rst),
        .in_req_i    (in_req),
        .in_word_i   (in_word),
        .in_ack_o    (in_ack),
        .out_req_o   (out_req),
        .out_result_o(out_result),
        .out_ack_i   (out_ack)
    );

    always #5 clk = ~clk;

    function automatic bit is_blank(input byte c);
        return (c == " ") || (c == "\t") || (c == "\n") || (c == "\r");
    endfunction

    // whitespace separated token starting at pos, pos moves past it
    function automatic string next_token(input string line, inout int pos);
        string tok;
        tok = "";
        while (pos < line.len() && is_blank(line.getc(pos))) begin
            pos++;
        end
        while (pos < line.len() && !is_blank(line.getc(pos))) begin
            tok = {tok, line.substr(pos, pos)};
            pos++;
        end
        return tok;
    endfunction

    task automatic load_vectors();
        int            fd;
        int            pos;
        int            count;
        string         line;
        string         tok;
        frame_result_t exp;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %s", VEC_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                pos = 0;
                tok = next_token(line, pos);
                if (tok.len() != 0 && tok.getc(0) != "#") begin
                    count = tok.atoi();
                    for (int i = 0; i < count; i++) begin
                        tok = next_token(line, pos);
                        stim_data_q.push_back(word_t'(tok.atohex()));
                        stim_last_q.push_back(1'b0);
                    end
                    // appended CRC word closes the frame
                    tok = next_token(line, pos);
                    stim_data_q.push_back(word_t'(tok.atohex()));
                    stim_last_q.push_back(1'b1);
                    exp.id  = frame_id_t'(num_frames);
                    tok     = next_token(line, pos);
                    exp.ok  = (tok.atoi() != 0);
                    tok     = next_token(line, pos);
                    exp.crc = crc_t'(tok.atohex());
                    if (tok.len() == 0) begin
                        $display("Vector line is missing columns: %s", line);
                        errors++;
                    end
                    exp_q.push_back(exp);
                    num_frames++;
                    num_words += count + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    // four-phase transfer of one word on the input port
    task automatic send_word(input word_t data, input logic last);
        int gap;
        gap = $urandom_range(5, 0);
        repeat (gap) wait_cycle();
        in_word.data = data;
        in_word.last = last;
        in_req       = 1'b1;
        while (!in_ack) wait_cycle();
        in_req = 1'b0;
        while (in_ack) wait_cycle();
    endtask

    task automatic check_result(input frame_result_t got);
        frame_result_t exp;
        if (exp_q.size() == 0) begin
            $display("Unexpected extra result at %0t with id %0d", $time, got.id);
            errors++;
        end else begin
            exp = exp_q.pop_front();
            assert (got.id == exp.id) else begin
                $display("Fail at %0t: result id %0d, expected %0d", $time, got.id, exp.id);
                errors++;
            end
            assert (got.ok == exp.ok) else begin
                $display("Fail at %0t: frame %0d ok %b, expected %b",
                         $time, exp.id, got.ok, exp.ok);
                errors++;
            end
            assert (got.crc == exp.crc) else begin
                $display("Fail at %0t: frame %0d crc %h, expected %h",
                         $time, exp.id, got.crc, exp.crc);
                errors++;
            end
            results_seen++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_req       = 1'b0;
        in_word      = '0;
        out_ack      = 1'b0;
        go           = 1'b0;
        errors       = 0;
        results_seen = 0;
        num_frames   = 0;
        num_words    = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        void'($urandom(32'hfc267712));
        load_vectors();
        cycle_limit = 200 + 40 * num_words;
        assert (num_frames > 0) else begin
            $display("No frames were read from the vector file");
            errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!in_ack && !out_req) else begin
            $display("Fail at %0t: in_ack %b out_req %b right after reset",
                     $time, in_ack, out_req);
            errors++;
        end
        go = 1'b1;
        while (results_seen < num_frames) wait_cycle();
        // a spurious extra result would show up here
        repeat (40) wait_cycle();
        assert (!out_req) else begin
            $display("Fail at %0t: out_req high after the last frame", $time);
            errors++;
        end
        $display("Errors: %0d, results %0d of %0d frames", errors, results_seen, num_frames);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : driver
        wait (go);
        while (stim_data_q.size() != 0) begin
            send_word(stim_data_q.pop_front(), stim_last_q.pop_front());
        end
    end

    // sink with random acknowledge delays, slow enough to back up the lanes
    initial begin : sink
        int delay;
        wait (go);
        forever begin
            wait_cycle();
            if (out_req) begin
                check_result(out_result);
                delay = $urandom_range(8, 0);
                repeat (delay) wait_cycle();
                out_ack = 1'b1;
                while (out_req) wait_cycle();
                out_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d results received",
                     cycle_cnt, results_seen, num_frames);
            $display("Errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

//--- testbench/crc_check_vectors.txt
# columns: payload word count (decimal), payload words, appended CRC word, expected ok, expected CRC
# words in hex, CRC-16 poly 1021, init FFFF, MSB first, no output inversion
1 1234 0EC9 1 0EC9
3 1234 5678 9ABC A840 1 A840
0 FFFF 1 FFFF
2 FFFF 1234 13C6 1 13C6
3 1234 5678 9ABD A840 0 B861
0 1234 0 FFFF
1 1235 0EC9 0 1EE8
6 1234 5678 9ABC 1234 5678 9ABC 5B52 1 5B52
1 0000 1D0F 1 1D0F
2 0000 0000 84C0 1 84C0
2 FFFF 1234 13C7 0 13C6
1 1234 0EC9 1 0EC9
3 1234 5678 9ABC A840 1 A840
0 FFFF 1 FFFF

//--- project.f
+incdir+rtl
rtl/crc_check_pkg.sv
rtl/crc_engine.sv
rtl/crc_lane.sv
rtl/frame_dispatch.sv
rtl/result_collect.sv
rtl/crc_check_top.sv
testbench/tb_crc_check.sv

//--- Makefile
# Verilator flow for the frame CRC checker, run from the project root

VERILATOR  ?= verilator
TOP        ?= tb_crc_check
RTL_TOP    ?= crc_check_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
